// File: soc_settings.svh
// SoC settings: bus widths, memory map, memory sizes and debug timing

`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 64
`define SOC_STRB_WIDTH 8

// ------------------------------
// Memory map
// ------------------------------
`define SOC_ROM_BASE     32'h0001_0000
`define SOC_ROM_WORDS    16
`define SOC_CLINT_BASE   32'h0200_0000
`define SOC_CLINT_LENGTH 32'h000C_0000
`define SOC_DRAM_BASE    32'h8000_0000
`define SOC_DRAM_WORDS   256

// CLINT register offsets inside its region
`define SOC_CLINT_MSIP_OFFSET     32'h0000_0000
`define SOC_CLINT_MTIMECMP_OFFSET 32'h0000_4000
`define SOC_CLINT_MTIME_OFFSET    32'h0000_BFF8

// ------------------------------
// Boot and debug
// ------------------------------
`define SOC_DEBUG_DELAY_CYCLES 64
`define SOC_ROM_NOP            32'h0000_0013

`endif

// File: soc_pkg.sv
// SoC package: shared bus, timer and target select types

`default_nettype none

`include "soc_settings.svh"

package soc_pkg;

  // Byte address on the request port
  typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;

  // One bus data word
  typedef logic [`SOC_DATA_WIDTH-1:0] data_t;

  // One enable per data byte
  typedef logic [`SOC_STRB_WIDTH-1:0] strb_t;

  // RISC-V mtime and mtimecmp are 64 bits on every XLEN
  typedef logic [63:0] mtime_t;

  // One-hot select, bit 2 ROM, bit 1 CLINT, bit 0 SRAM
  typedef logic [2:0] target_sel_t;

endpackage

`default_nettype wire

// File: reset_ctrl.sv
// Reset controller: system reset from power-on and ndmreset, debug request hold-off

`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  output logic rst_sys_no,
  output logic debug_req_o
);

  localparam int unsigned cnt_width = $clog2(`SOC_DEBUG_DELAY_CYCLES + 1);

  logic                 rst_comb_n;
  logic                 rst_sync_q1;
  logic                 rst_sync_q2;
  logic [cnt_width-1:0] dbg_cnt_q;

  // ------------------------------
  // System reset
  // ------------------------------
  // Either source asserts at once, release is synchronized
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      rst_sync_q1 <= 1'b0;
      rst_sync_q2 <= 1'b0;
    end else begin
      rst_sync_q1 <= 1'b1;
      rst_sync_q2 <= rst_sync_q1;
    end
  end

  assign rst_sys_no = rst_sync_q2;

  // ------------------------------
  // Debug hold-off window
  // ------------------------------
  // Only power-on reset restarts the window, ndmreset leaves it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_cnt_q <= cnt_width'(`SOC_DEBUG_DELAY_CYCLES);
    end else if (dbg_cnt_q != '0) begin
      dbg_cnt_q <= dbg_cnt_q - 1'b1;
    end
  end

  // Boot code runs undisturbed until the window closes
  assign debug_req_o = (dbg_cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

`default_nettype wire

// File: mem_bus_router.sv
// Memory bus router: address decode to ROM, CLINT and SRAM, in-order response mux

`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module mem_bus_router (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::data_t rom_rdata_i,
  input  soc_pkg::data_t sram_rdata_i,
  input  soc_pkg::data_t clint_rdata_i,
  output logic           rom_req_o,
  output logic           sram_req_o,
  output logic           clint_req_o,
  output logic           we_o,
  output soc_pkg::addr_t word_addr_o,
  output soc_pkg::strb_t be_o,
  output soc_pkg::data_t wdata_o,
  output logic           rvalid_o,
  output logic           err_o,
  output soc_pkg::data_t rdata_o
);

  // End addresses, exclusive
  localparam soc_pkg::addr_t rom_end   = `SOC_ROM_BASE + `SOC_ROM_WORDS * `SOC_STRB_WIDTH;
  localparam soc_pkg::addr_t clint_end = `SOC_CLINT_BASE + `SOC_CLINT_LENGTH;
  localparam soc_pkg::addr_t dram_end  = `SOC_DRAM_BASE + `SOC_DRAM_WORDS * `SOC_STRB_WIDTH;

  logic                 hit_rom;
  logic                 hit_clint;
  logic                 hit_sram;
  logic                 err_d;
  soc_pkg::target_sel_t sel_d;
  soc_pkg::target_sel_t sel_q;
  logic                 valid_q;
  logic                 err_q;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign hit_rom   = (addr_i >= `SOC_ROM_BASE) && (addr_i < rom_end);
  assign hit_clint = (addr_i >= `SOC_CLINT_BASE) && (addr_i < clint_end);
  assign hit_sram  = (addr_i >= `SOC_DRAM_BASE) && (addr_i < dram_end);

  // ROM writes never reach the ROM
  assign sel_d = {hit_rom & ~we_i, hit_clint, hit_sram} & {3{req_i}};
  assign err_d = req_i & (sel_d == '0);

  assign rom_req_o   = sel_d[2];
  assign clint_req_o = sel_d[1];
  assign sram_req_o  = sel_d[0];

  // Shared request fields
  assign we_o    = we_i;
  assign be_o    = be_i;
  assign wdata_o = wdata_i;

  // Offset within the selected region
  always_comb begin
    word_addr_o = addr_i;
    if (hit_rom) begin
      word_addr_o = addr_i - `SOC_ROM_BASE;
    end else if (hit_clint) begin
      word_addr_o = addr_i - `SOC_CLINT_BASE;
    end else if (hit_sram) begin
      word_addr_o = addr_i - `SOC_DRAM_BASE;
    end
  end

  // ------------------------------
  // Response cycle
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q   <= '0;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      sel_q   <= sel_d;
      valid_q <= req_i;
      err_q   <= err_d;
    end
  end

  // Error responses have no select and so return zero
  always_comb begin
    case (sel_q)
      3'b100:  rdata_o = rom_rdata_i;
      3'b010:  rdata_o = clint_rdata_i;
      3'b001:  rdata_o = sram_rdata_i;
      default: rdata_o = '0;
    endcase
  end

  assign rvalid_o = valid_q;
  assign err_o    = err_q;

endmodule

`default_nettype wire

// File: boot_rom.sv
// Boot ROM: fixed contents with a registered read

`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module boot_rom (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  soc_pkg::addr_t addr_i,
  output soc_pkg::data_t rdata_o
);

  localparam int unsigned idx_bits = $clog2(`SOC_ROM_WORDS);
  localparam int unsigned off_bits = $clog2(`SOC_STRB_WIDTH);

  logic [idx_bits-1:0] rom_idx;

  // Upper address bits drop out, so the index wraps
  assign rom_idx = addr_i[off_bits +: idx_bits];

  // Word i is {i, nop}
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= {32'(rom_idx), `SOC_ROM_NOP};
    end
  end

endmodule

`default_nettype wire

// File: sram.sv
// Main memory: single-port, byte-enabled SRAM with a registered read

`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module sram (
  input  logic           clk_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output soc_pkg::data_t rdata_o
);

  localparam int unsigned idx_bits = $clog2(`SOC_DRAM_WORDS);
  localparam int unsigned off_bits = $clog2(`SOC_STRB_WIDTH);

  soc_pkg::data_t      mem_q [`SOC_DRAM_WORDS];
  logic [idx_bits-1:0] word_idx;

  // Byte offset to word index
  assign word_idx = addr_i[off_bits +: idx_bits];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < `SOC_STRB_WIDTH; i++) begin
          if (be_i[i]) begin
            mem_q[word_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
        // Write response carries no data
        rdata_o <= '0;
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: clint_timer.sv
// CLINT timer: mtime counter on rtc edges, mtimecmp compare and msip software interrupt

`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module clint_timer (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           rtc_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output soc_pkg::data_t rdata_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);

  logic            rtc_q1;
  logic            rtc_q2;
  logic            rtc_q3;
  logic            rtc_rise;
  soc_pkg::addr_t  reg_addr;
  logic            sel_msip;
  logic            sel_mtimecmp;
  logic            sel_mtime;
  soc_pkg::mtime_t mtime_q;
  soc_pkg::mtime_t mtimecmp_q;
  logic            msip_q;

  // Keeps the old bytes where the enable is low
  function automatic soc_pkg::data_t merge_be(input soc_pkg::data_t old_val,
                                              input soc_pkg::data_t new_val,
                                              input soc_pkg::strb_t be);
    soc_pkg::data_t res;
    res = old_val;
    for (int i = 0; i < `SOC_STRB_WIDTH; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // RTC synchronizer
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q1 <= 1'b0;
      rtc_q2 <= 1'b0;
      rtc_q3 <= 1'b0;
    end else begin
      rtc_q1 <= rtc_i;
      rtc_q2 <= rtc_q1;
      rtc_q3 <= rtc_q2;
    end
  end

  assign rtc_rise = rtc_q2 & ~rtc_q3;

  // ------------------------------
  // Register decode
  // ------------------------------
  // Registers are word aligned
  assign reg_addr     = {addr_i[`SOC_ADDR_WIDTH-1:3], 3'b000};
  assign sel_msip     = req_i && (reg_addr == `SOC_CLINT_MSIP_OFFSET);
  assign sel_mtimecmp = req_i && (reg_addr == `SOC_CLINT_MTIMECMP_OFFSET);
  assign sel_mtime    = req_i && (reg_addr == `SOC_CLINT_MTIME_OFFSET);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      // Software write wins over a tick in the same cycle
      if (sel_mtime && we_i) begin
        mtime_q <= merge_be(mtime_q, wdata_i, be_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (sel_mtimecmp && we_i) begin
        mtimecmp_q <= merge_be(mtimecmp_q, wdata_i, be_i);
      end
      if (sel_msip && we_i && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  // Registered read, unused offsets read zero
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else if (sel_mtime) begin
        rdata_o <= mtime_q;
      end else if (sel_mtimecmp) begin
        rdata_o <= mtimecmp_q;
      end else if (sel_msip) begin
        rdata_o <= {{(`SOC_DATA_WIDTH-1){1'b0}}, msip_q};
      end else begin
        rdata_o <= '0;
      end
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// File: soc_harness.sv
// SoC harness top: reset control, bus router, boot ROM, SRAM and CLINT timer

`timescale 1ns/1ps
`default_nettype none

module soc_harness (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           rtc_i,
  input  logic           ndmreset_i,
  input  logic           debug_req_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t be_i,
  input  soc_pkg::data_t wdata_i,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o,
  output logic           err_o,
  output logic           timer_irq_o,
  output logic           ipi_o,
  output logic           debug_req_o
);

  logic           rst_sys_n;
  logic           rom_req;
  logic           sram_req;
  logic           clint_req;
  logic           tgt_we;
  soc_pkg::addr_t tgt_addr;
  soc_pkg::strb_t tgt_be;
  soc_pkg::data_t tgt_wdata;
  soc_pkg::data_t rom_rdata;
  soc_pkg::data_t sram_rdata;
  soc_pkg::data_t clint_rdata;

  // ------------------------------
  // Reset and debug
  // ------------------------------
  reset_ctrl i_reset_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .rst_sys_no  ( rst_sys_n   ),
    .debug_req_o ( debug_req_o )
  );

  // ------------------------------
  // Bus
  // ------------------------------
  mem_bus_router i_mem_bus_router (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_sys_n   ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .be_i          ( be_i        ),
    .wdata_i       ( wdata_i     ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata ),
    .rom_req_o     ( rom_req     ),
    .sram_req_o    ( sram_req    ),
    .clint_req_o   ( clint_req   ),
    .we_o          ( tgt_we      ),
    .word_addr_o   ( tgt_addr    ),
    .be_o          ( tgt_be      ),
    .wdata_o       ( tgt_wdata   ),
    .rvalid_o      ( rvalid_o    ),
    .err_o         ( err_o       ),
    .rdata_o       ( rdata_o     )
  );

  // ------------------------------
  // Targets
  // ------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_sys_n ),
    .req_i   ( rom_req   ),
    .addr_i  ( tgt_addr  ),
    .rdata_o ( rom_rdata )
  );

  // Contents survive ndmreset
  sram i_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( tgt_we     ),
    .addr_i  ( tgt_addr   ),
    .be_i    ( tgt_be     ),
    .wdata_i ( tgt_wdata  ),
    .rdata_o ( sram_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_sys_n   ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( tgt_we      ),
    .addr_i      ( tgt_addr    ),
    .be_i        ( tgt_be      ),
    .wdata_i     ( tgt_wdata   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

`default_nettype wire

// File: tb_soc_harness.sv
// Testbench for the SoC harness: debug window, SRAM, ROM decode, CLINT and debug reset

`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module tb_soc_harness;

  logic           clk_i;
  logic           rst_ni;
  logic           rtc_i;
  logic           ndmreset_i;
  logic           debug_req_i;
  logic           req_i;
  logic           we_i;
  soc_pkg::addr_t addr_i;
  soc_pkg::strb_t be_i;
  soc_pkg::data_t wdata_i;
  logic           rvalid_o;
  soc_pkg::data_t rdata_o;
  logic           err_o;
  logic           timer_irq_o;
  logic           ipi_o;
  logic           debug_req_o;

  logic [31:0]    lfsr_state;
  soc_pkg::data_t ref_mem [`SOC_DRAM_WORDS];

  // Expected responses in request order
  soc_pkg::data_t exp_data_q [$];
  logic           exp_err_q [$];
  logic           exp_mtime_q [$];
  string          exp_name_q [$];

  soc_harness DUT (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .rvalid_o    ( rvalid_o    ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------
  // Random numbers and reference
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return r;
  endfunction

  function automatic soc_pkg::data_t ref_merge(input soc_pkg::data_t old_word,
                                               input soc_pkg::data_t new_word,
                                               input soc_pkg::strb_t be);
    soc_pkg::data_t mask;
    for (int b = 0; b < `SOC_STRB_WIDTH; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic soc_pkg::data_t rom_word(input soc_pkg::addr_t a);
    soc_pkg::addr_t idx;
    idx = ((a - `SOC_ROM_BASE) / 32'(`SOC_STRB_WIDTH)) % 32'(`SOC_ROM_WORDS);
    return {idx, `SOC_ROM_NOP};
  endfunction

  // Unmapped addresses and ROM writes answer with an error
  function automatic logic decode_error(input soc_pkg::addr_t a, input logic we);
    logic in_rom;
    logic in_clint;
    logic in_dram;
    in_rom   = (a >= `SOC_ROM_BASE) &&
               (a < `SOC_ROM_BASE + 32'(`SOC_ROM_WORDS * `SOC_STRB_WIDTH));
    in_clint = (a >= `SOC_CLINT_BASE) && (a < `SOC_CLINT_BASE + `SOC_CLINT_LENGTH);
    in_dram  = (a >= `SOC_DRAM_BASE) &&
               (a < `SOC_DRAM_BASE + 32'(`SOC_DRAM_WORDS * `SOC_STRB_WIDTH));
    return !(in_clint || in_dram || (in_rom && !we));
  endfunction

  // Sixteen SRAM words spread over the array
  function automatic soc_pkg::addr_t sram_addr(input int k);
    return `SOC_DRAM_BASE + 32'(k * 17 * `SOC_STRB_WIDTH);
  endfunction

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_data(input string name, input soc_pkg::data_t exp,
                            input soc_pkg::data_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s err expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mtime(input string name, input soc_pkg::mtime_t exp,
                             input soc_pkg::mtime_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Response comes one cycle after each request taken
  initial begin : response_checker
    logic           pending;
    soc_pkg::data_t e_data;
    logic           e_err;
    logic           e_mtime;
    string          e_name;
    forever begin
      @(posedge clk_i);
      pending = req_i;
      @(negedge clk_i);
      check_flag("rvalid", pending, rvalid_o);
      if (pending) begin
        if (exp_data_q.size() == 0) begin
          $display("A response arrived with no request on record");
          abort_run();
        end
        e_data  = exp_data_q.pop_front();
        e_err   = exp_err_q.pop_front();
        e_mtime = exp_mtime_q.pop_front();
        e_name  = exp_name_q.pop_front();
        if (e_mtime) begin
          check_mtime(e_name, soc_pkg::mtime_t'(e_data), soc_pkg::mtime_t'(rdata_o));
        end else begin
          check_data(e_name, e_data, rdata_o);
        end
        check_err(e_name, e_err, err_o);
      end
    end
  end

  // ------------------------------
  // Bus driver
  // ------------------------------
  task automatic send_req(input string name, input logic we, input soc_pkg::addr_t a,
                          input soc_pkg::strb_t be, input soc_pkg::data_t wd,
                          input soc_pkg::data_t exp, input logic is_mtime);
    logic e_err;
    e_err = decode_error(a, we);
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = a;
    be_i    = be;
    wdata_i = wd;
    exp_data_q.push_back(e_err ? '0 : exp);
    exp_err_q.push_back(e_err);
    exp_mtime_q.push_back(is_mtime);
    exp_name_q.push_back(name);
  endtask

  task automatic release_bus();
    int n;
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
    n = 0;
    while (exp_data_q.size() != 0 && n < 20) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_data_q.size() != 0) begin
      $display("Timeout: bus responses still outstanding");
      abort_run();
    end
  endtask

  task automatic wait_level(input logic use_ipi, input logic level, input string what);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < 16) begin
      @(negedge clk_i);
      seen = ((use_ipi ? ipi_o : timer_irq_o) === level);
      n++;
    end
    if (!seen) begin
      $display("Timeout: %s never reached the expected level", what);
      abort_run();
    end
  endtask

  task automatic pulse_rtc(input int count);
    for (int p = 0; p < count; p++) begin
      @(negedge clk_i);
      rtc_i = 1'b1;
      repeat (3) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (2) @(negedge clk_i);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main_sequence
    int             n_rtc;
    int             k;
    soc_pkg::strb_t be;
    soc_pkg::data_t wd;
    soc_pkg::addr_t a;
    lfsr_state  = 32'ha2d;
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    ndmreset_i  = 1'b0;
    debug_req_i = 1'b1;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    be_i        = '0;
    wdata_i     = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // Debug window opens on the 64th edge
    for (int e = 1; e <= `SOC_DEBUG_DELAY_CYCLES; e++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_flag("debug window", e >= `SOC_DEBUG_DELAY_CYCLES, debug_req_o);
    end
    check_flag("err after reset", 1'b0, err_o);
    check_flag("ipi after reset", 1'b0, ipi_o);
    check_flag("timer irq after reset", 1'b0, timer_irq_o);

    // SRAM: full writes, random byte-enable writes, then reads
    for (int i = 0; i < 16; i++) begin
      wd = rand_bits(64);
      ref_mem[i*17] = wd;
      send_req("sram fill", 1'b1, sram_addr(i), 8'hff, wd, '0, 1'b0);
    end
    for (int i = 0; i < 32; i++) begin
      k  = int'(rand_bits(4));
      be = soc_pkg::strb_t'(rand_bits(8));
      wd = rand_bits(64);
      ref_mem[k*17] = ref_merge(ref_mem[k*17], wd, be);
      send_req("sram byte write", 1'b1, sram_addr(k), be, wd, '0, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      send_req("sram read", 1'b0, sram_addr(i), 8'hff, '0, ref_mem[i*17], 1'b0);
    end
    release_bus();

    // ROM contents and decode errors
    for (int i = 0; i < 16; i++) begin
      a = `SOC_ROM_BASE + 32'(int'(rand_bits(4)) * `SOC_STRB_WIDTH);
      send_req("rom read", 1'b0, a, 8'hff, '0, rom_word(a), 1'b0);
    end
    a = `SOC_ROM_BASE + 32'h8;
    send_req("rom write", 1'b1, a, 8'hff, 64'hdead_beef, '0, 1'b0);
    send_req("rom read after write", 1'b0, a, 8'hff, '0, rom_word(a), 1'b0);
    send_req("unmapped read", 1'b0, 32'h0000_0000, 8'hff, '0, '0, 1'b0);
    send_req("unmapped write", 1'b1, 32'h4000_0000, 8'hff, 64'h1, '0, 1'b0);
    send_req("past rom end", 1'b0, `SOC_ROM_BASE + 32'h80, 8'hff, '0, '0, 1'b0);
    send_req("clint hole", 1'b0, `SOC_CLINT_BASE + 32'h100, 8'hff, '0, '0, 1'b0);
    release_bus();

    // CLINT: mtime from rtc edges, compare, software interrupt
    check_flag("timer irq idle", 1'b0, timer_irq_o);
    n_rtc = 3 + int'(rand_bits(3));
    pulse_rtc(n_rtc);
    repeat (4) @(negedge clk_i);
    a = `SOC_CLINT_BASE + `SOC_CLINT_MTIME_OFFSET;
    send_req("mtime count", 1'b0, a, 8'hff, '0, soc_pkg::data_t'(n_rtc), 1'b1);
    a = `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_OFFSET;
    send_req("mtimecmp write", 1'b1, a, 8'hff, soc_pkg::data_t'(n_rtc - 1), '0, 1'b0);
    send_req("mtimecmp read", 1'b0, a, 8'hff, '0, soc_pkg::data_t'(n_rtc - 1), 1'b1);
    release_bus();
    wait_level(1'b0, 1'b1, "timer irq");
    send_req("msip set", 1'b1, `SOC_CLINT_BASE, 8'h01, 64'h1, '0, 1'b0);
    release_bus();
    wait_level(1'b1, 1'b1, "ipi set");
    send_req("msip clear", 1'b1, `SOC_CLINT_BASE, 8'h01, 64'h0, '0, 1'b0);
    release_bus();
    wait_level(1'b1, 1'b0, "ipi clear");

    // Debug reset leaves SRAM and the debug window alone
    @(negedge clk_i);
    ndmreset_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("debug during ndmreset", 1'b1, debug_req_o);
    end
    ndmreset_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("debug after ndmreset", 1'b1, debug_req_o);
    end
    check_flag("ipi after ndmreset", 1'b0, ipi_o);
    check_flag("timer irq after ndmreset", 1'b0, timer_irq_o);
    a = `SOC_CLINT_BASE + `SOC_CLINT_MTIME_OFFSET;
    send_req("mtime after ndmreset", 1'b0, a, 8'hff, '0, '0, 1'b1);
    for (int i = 0; i < 16; i++) begin
      send_req("sram kept", 1'b0, sram_addr(i), 8'hff, '0, ref_mem[i*17], 1'b0);
    end
    release_bus();
    check_flag("debug at end", 1'b1, debug_req_o);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
soc_pkg.sv
reset_ctrl.sv
mem_bus_router.sv
boot_rom.sv
sram.sv
clint_timer.sv
soc_harness.sv
tb_soc_harness.sv

// File: run.sh
#!/usr/bin/env bash
# Build the SoC harness testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_soc_harness -f sources.f -o sim_tb

output="$(./obj_dir/sim_tb 2>&1)" || true
echo "$output"

if grep -q "=== PASS ===" <<< "$output"; then
  exit 0
else
  exit 1
fi
